// File: rtl/lsu_defines.svh
// ====================
// queue sizes and bus widths for the load/store ordering core
// include wherever a size or width is needed
// ====================
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// load queue depth
// power of two so head and tail wrap on their own
`define LDQ_SIZE 8

// store queue depth, also a power of two
`define STQ_SIZE 8

// address and store data width
`define XLEN 32

// width of a ROB tag
`define ROB_TAG_WIDTH 6

`endif

// File: rtl/lsu_pkg.sv
// ====================
// shared bus, entry and report types of the load/store ordering core
// ====================
`include "lsu_defines.svh"

package lsu_pkg;

	// one-cycle strobe carrying a ROB tag
	// used for allocate, executed, succeeded and commit
	typedef struct packed {
		logic valid;
		logic [`ROB_TAG_WIDTH-1:0] rob_tag;
	} tag_event_t;

	// address generation result, loads ignore data
	typedef struct packed {
		logic valid;
		logic [`ROB_TAG_WIDTH-1:0] rob_tag;
		logic [`XLEN-1:0] address;
		logic [`XLEN-1:0] data;
	} agu_update_t;

	// one in-flight load
	// store_mask marks the stores that are older than this load
	typedef struct packed {
		logic valid;
		logic address_valid;
		logic executed;
		logic succeeded;
		logic committed;
		logic order_fail;
		logic [`XLEN-1:0] address;
		logic [`ROB_TAG_WIDTH-1:0] rob_tag;
		logic [`STQ_SIZE-1:0] store_mask;
	} ldq_entry_t;

	// life of a store queue entry
	typedef enum logic [1:0] {
		STQ_EMPTY,
		STQ_WAIT_ADDR,
		STQ_READY,
		STQ_COMMITTED
	} stq_state_t;

	typedef struct packed {
		stq_state_t state;
		logic [`ROB_TAG_WIDTH-1:0] rob_tag;
		logic [`XLEN-1:0] address;
		logic [`XLEN-1:0] data;
	} stq_entry_t;

	// a store has just committed, check it against the loads
	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] address;
		logic [$clog2(`STQ_SIZE)-1:0] stq_index;
	} store_commit_t;

	// committed store leaving for memory
	typedef struct packed {
		logic valid;
		logic [$clog2(`STQ_SIZE)-1:0] stq_index;
		logic [`XLEN-1:0] address;
		logic [`XLEN-1:0] data;
	} store_fire_t;

	// committed load leaving the load queue
	typedef struct packed {
		logic valid;
		logic [`ROB_TAG_WIDTH-1:0] rob_tag;
		logic order_fail;
	} load_retire_t;

endpackage

// File: rtl/load_queue.sv
// ====================
// circular buffer of in-flight loads in program order
// entries update by ROB tag and the committed head retires with its order_fail bit
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module load_queue (
	input  logic clk,
	input  logic reset,

	// new load from dispatch and the stores that are older than it
	input  lsu_pkg::tag_event_t alloc,
	input  logic [`STQ_SIZE-1:0] alloc_store_mask,

	// address, execution and completion events by ROB tag
	input  lsu_pkg::agu_update_t agu,
	input  lsu_pkg::tag_event_t executed,
	input  lsu_pkg::tag_event_t succeeded,
	input  lsu_pkg::tag_event_t commit,

	// one bit per entry from the order fail checker
	input  logic [`LDQ_SIZE-1:0] order_failures,

	// a store that left the store queue drops out of every mask
	input  logic stq_fired,
	input  logic [$clog2(`STQ_SIZE)-1:0] stq_fired_index,

	output lsu_pkg::ldq_entry_t [`LDQ_SIZE-1:0] entries,
	output logic full,
	output lsu_pkg::load_retire_t retire
);
	import lsu_pkg::*;

	localparam int LDQ_IDX_W = $clog2(`LDQ_SIZE);

	// head is the oldest load and tail the next free slot
	logic [LDQ_IDX_W-1:0] head;
	logic [LDQ_IDX_W-1:0] tail;

	ldq_entry_t head_entry;
	logic head_free;

	// does this event name a live entry
	function automatic logic tag_hit(
		input ldq_entry_t e,
		input logic ev_valid,
		input logic [`ROB_TAG_WIDTH-1:0] ev_tag
	);
		return e.valid && ev_valid && (e.rob_tag == ev_tag);
	endfunction

	assign head_entry = entries[head];
	assign head_free = head_entry.valid && head_entry.committed;

	// tail slot still holds a live load means no room
	assign full = entries[tail].valid;

	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			retire.valid <= 1'b0;
			for (int i = 0; i < `LDQ_SIZE; i++) begin
				entries[i].valid <= 1'b0;
				entries[i].address_valid <= 1'b0;
				entries[i].executed <= 1'b0;
				entries[i].succeeded <= 1'b0;
				entries[i].committed <= 1'b0;
				entries[i].order_fail <= 1'b0;
			end
		end else begin
			// every entry compares every bus in the same cycle
			for (int i = 0; i < `LDQ_SIZE; i++) begin
				if (tag_hit(entries[i], agu.valid, agu.rob_tag)) begin
					entries[i].address <= agu.address;
					entries[i].address_valid <= 1'b1;
				end
				if (tag_hit(entries[i], executed.valid, executed.rob_tag)) begin
					entries[i].executed <= 1'b1;
				end
				if (tag_hit(entries[i], succeeded.valid, succeeded.rob_tag)) begin
					entries[i].succeeded <= 1'b1;
				end
				// commit only marks the entry and freeing waits for the head
				if (tag_hit(entries[i], commit.valid, commit.rob_tag)) begin
					entries[i].committed <= 1'b1;
				end
				// order failures are sticky until retire
				entries[i].order_fail <= entries[i].order_fail | order_failures[i];
				if (stq_fired) begin
					entries[i].store_mask[stq_fired_index] <= 1'b0;
				end
			end

			// report the head as it leaves
			// a failure flagged on this very edge still counts
			retire.valid <= head_free;
			retire.rob_tag <= head_entry.rob_tag;
			retire.order_fail <= head_entry.order_fail | order_failures[head];

			// freeing a committed head overrides the per entry updates above
			if (head_free) begin
				entries[head].valid <= 1'b0;
				entries[head].address_valid <= 1'b0;
				entries[head].executed <= 1'b0;
				entries[head].succeeded <= 1'b0;
				entries[head].committed <= 1'b0;
				entries[head].order_fail <= 1'b0;
				head <= head + 1'b1;
			end

			// allocation while full is dropped
			if (alloc.valid && !full) begin
				entries[tail].valid <= 1'b1;
				entries[tail].rob_tag <= alloc.rob_tag;
				entries[tail].store_mask <= alloc_store_mask;
				tail <= tail + 1'b1;
			end
		end
	end

endmodule

// File: rtl/store_queue.sv
// ====================
// circular buffer of in-flight stores in program order
// publishes each commit for ordering checks and writes committed heads to memory
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module store_queue (
	input  logic clk,
	input  logic reset,

	input  lsu_pkg::tag_event_t alloc,
	input  lsu_pkg::agu_update_t agu,
	input  lsu_pkg::tag_event_t commit,

	// one bit per entry that holds a store
	output logic [`STQ_SIZE-1:0] occupied,
	output logic full,

	output lsu_pkg::store_commit_t store_commit,
	output lsu_pkg::store_fire_t fire
);
	import lsu_pkg::*;

	localparam int STQ_IDX_W = $clog2(`STQ_SIZE);

	stq_entry_t entries [`STQ_SIZE];

	// head is the oldest store, tail the next free slot
	logic [STQ_IDX_W-1:0] head;
	logic [STQ_IDX_W-1:0] tail;
	logic head_done;

	always_comb begin
		for (int i = 0; i < `STQ_SIZE; i++) begin
			occupied[i] = (entries[i].state != STQ_EMPTY);
		end
	end

	assign full = occupied[tail];
	assign head_done = (entries[head].state == STQ_COMMITTED);

	always_ff @(posedge clk) begin
		if (!reset) begin
			head <= '0;
			tail <= '0;
			store_commit.valid <= 1'b0;
			fire.valid <= 1'b0;
			for (int i = 0; i < `STQ_SIZE; i++) begin
				entries[i].state <= STQ_EMPTY;
			end
		end else begin
			// commit event is a one-cycle strobe
			store_commit.valid <= 1'b0;

			for (int i = 0; i < `STQ_SIZE; i++) begin
				case (entries[i].state)
					// address and data arrive together from the AGU
					STQ_WAIT_ADDR: begin
						if (agu.valid && agu.rob_tag == entries[i].rob_tag) begin
							entries[i].address <= agu.address;
							entries[i].data <= agu.data;
							entries[i].state <= STQ_READY;
						end
					end
					// commit from the ROB, tell the checker where this store writes
					STQ_READY: begin
						if (commit.valid && commit.rob_tag == entries[i].rob_tag) begin
							entries[i].state <= STQ_COMMITTED;
							store_commit.valid <= 1'b1;
							store_commit.address <= entries[i].address;
							store_commit.stq_index <= STQ_IDX_W'(i);
						end
					end
					default: begin
					end
				endcase
			end

			// memory always accepts, so a committed head leaves right away
			fire.valid <= head_done;
			fire.stq_index <= head;
			fire.address <= entries[head].address;
			fire.data <= entries[head].data;
			if (head_done) begin
				entries[head].state <= STQ_EMPTY;
				head <= head + 1'b1;
			end

			// allocation while full is dropped
			if (alloc.valid && !full) begin
				entries[tail].state <= STQ_WAIT_ADDR;
				entries[tail].rob_tag <= alloc.rob_tag;
				tail <= tail + 1'b1;
			end
		end
	end

endmodule

// File: rtl/order_fail_checker.sv
// ====================
// flags every load that ran ahead of a committing store to the same word
// purely combinational, load_queue registers the result
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module order_fail_checker (
	input  lsu_pkg::store_commit_t store_commit,
	input  lsu_pkg::ldq_entry_t [`LDQ_SIZE-1:0] ldq_entries,
	output logic [`LDQ_SIZE-1:0] order_failures
);
	import lsu_pkg::*;

	ldq_entry_t entry;
	logic addr_match;
	logic is_younger;

	always_comb begin
		entry = '0;
		addr_match = 1'b0;
		is_younger = 1'b0;
		for (int i = 0; i < `LDQ_SIZE; i++) begin
			entry = ldq_entries[i];

			// whole word compare, no byte sizes
			addr_match = (entry.address == store_commit.address);

			// the mask bit says the store was in flight when the load
			// was allocated, so the load is younger
			is_younger = entry.store_mask[store_commit.stq_index];

			// load must already have its address and have executed
			order_failures[i] = store_commit.valid
				&& entry.valid
				&& entry.address_valid
				&& entry.executed
				&& addr_match
				&& is_younger;
		end
	end

endmodule

// File: rtl/lsu_top.sv
// ====================
// memory ordering core of the load/store unit
// load queue, store queue and the order fail checker between them
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
	input  logic clk,
	input  logic reset,

	// dispatch side
	input  lsu_pkg::tag_event_t ld_alloc,
	input  lsu_pkg::tag_event_t st_alloc,
	output logic ldq_full,
	output logic stq_full,

	// shared AGU bus for loads and stores
	input  lsu_pkg::agu_update_t agu,

	// load progress from the cache side
	input  lsu_pkg::tag_event_t load_executed,
	input  lsu_pkg::tag_event_t load_succeeded,

	// shared ROB commit bus
	input  lsu_pkg::tag_event_t rob_commit,

	output lsu_pkg::store_fire_t store_fire,
	output lsu_pkg::load_retire_t load_retire
);
	import lsu_pkg::*;

	// every store still in the queue is older than a new load
	logic [`STQ_SIZE-1:0] stq_occupied;
	store_commit_t store_commit;
	ldq_entry_t [`LDQ_SIZE-1:0] ldq_entries;
	logic [`LDQ_SIZE-1:0] order_failures;

	load_queue i_load_queue (
		.clk(clk),
		.reset(reset),
		.alloc(ld_alloc),
		.alloc_store_mask(stq_occupied),
		.agu(agu),
		.executed(load_executed),
		.succeeded(load_succeeded),
		.commit(rob_commit),
		.order_failures(order_failures),
		.stq_fired(store_fire.valid),
		.stq_fired_index(store_fire.stq_index),
		.entries(ldq_entries),
		.full(ldq_full),
		.retire(load_retire)
	);

	store_queue i_store_queue (
		.clk(clk),
		.reset(reset),
		.alloc(st_alloc),
		.agu(agu),
		.commit(rob_commit),
		.occupied(stq_occupied),
		.full(stq_full),
		.store_commit(store_commit),
		.fire(store_fire)
	);

	order_fail_checker i_order_fail_checker (
		.store_commit(store_commit),
		.ldq_entries(ldq_entries),
		.order_failures(order_failures)
	);

endmodule

// File: test/lsu_assert.sv
// ====================
// concurrent checks on the top-level outputs, bound to lsu_top
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_assert (
	input  logic clk,
	input  logic reset,
	input  lsu_pkg::store_fire_t store_fire,
	input  lsu_pkg::load_retire_t load_retire
);
	import lsu_pkg::*;

	localparam int STQ_IDX_W = $clog2(`STQ_SIZE);

	// index of the last store written out, starts one below entry 0
	logic [STQ_IDX_W-1:0] last_fire_index;
	logic [STQ_IDX_W-1:0] next_fire_index;

	assign next_fire_index = last_fire_index + 1'b1;

	always_ff @(posedge clk) begin
		if (!reset) begin
			last_fire_index <= STQ_IDX_W'(`STQ_SIZE - 1);
		end else if (store_fire.valid) begin
			last_fire_index <= store_fire.stq_index;
		end
	end

	// stores leave in queue order
	fire_in_order: assert property (@(posedge clk) disable iff (!reset)
		store_fire.valid |-> store_fire.stq_index == next_fire_index)
		else $error("store_fire index does not follow the previous fire");

	// each report is a one-cycle strobe, back to back only for another entry
	retire_strobe: assert property (@(posedge clk) disable iff (!reset)
		load_retire.valid && $past(load_retire.valid)
		|-> load_retire.rob_tag != $past(load_retire.rob_tag))
		else $error("load_retire held for a second cycle");

	fire_strobe: assert property (@(posedge clk) disable iff (!reset)
		store_fire.valid && $past(store_fire.valid)
		|-> store_fire.stq_index != $past(store_fire.stq_index))
		else $error("store_fire held for a second cycle");

	// reset is synchronous, so outputs are quiet from the second reset edge on
	quiet_in_reset: assert property (@(posedge clk)
		!reset && $past(!reset) |-> !load_retire.valid && !store_fire.valid)
		else $error("retire or fire while reset is asserted");

endmodule

bind lsu_top lsu_assert i_lsu_assert (
	.clk(clk),
	.reset(reset),
	.store_fire(store_fire),
	.load_retire(load_retire)
);

// File: test/lsu_tb.sv
// ====================
// directed and random tests for the load/store ordering core
// a scoreboard checks every retire and fire, one result line at the end
// ====================
`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_tb;
	import lsu_pkg::*;

	typedef logic [`ROB_TAG_WIDTH-1:0] tag_t;
	typedef logic [$clog2(`STQ_SIZE)-1:0] stq_idx_t;
	typedef logic [`XLEN-1:0] word_t;

	// tests take about 700 cycles, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 3000;

	// bus selectors for send_event
	localparam int BUS_LD_ALLOC = 0;
	localparam int BUS_ST_ALLOC = 1;
	localparam int BUS_EXECUTED = 2;
	localparam int BUS_SUCCEEDED = 3;
	localparam int BUS_COMMIT = 4;

	logic clk;
	logic reset;
	tag_event_t ld_alloc;
	tag_event_t st_alloc;
	agu_update_t agu;
	tag_event_t load_executed;
	tag_event_t load_succeeded;
	tag_event_t rob_commit;
	logic ldq_full;
	logic stq_full;
	store_fire_t store_fire;
	load_retire_t load_retire;

	// expected reports, in the order the DUT must give them
	load_retire_t exp_retire[$];
	store_fire_t exp_fire[$];
	load_retire_t want_retire;
	store_fire_t want_fire;

	int errors = 0;
	int cycles = 0;
	int seed;
	tag_t next_tag = '0;
	// model of the store queue tail, advances on each accepted store
	stq_idx_t store_index = '0;

	lsu_top i_lsu_top (
		.clk(clk),
		.reset(reset),
		.ld_alloc(ld_alloc),
		.st_alloc(st_alloc),
		.ldq_full(ldq_full),
		.stq_full(stq_full),
		.agu(agu),
		.load_executed(load_executed),
		.load_succeeded(load_succeeded),
		.rob_commit(rob_commit),
		.store_fire(store_fire),
		.load_retire(load_retire)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, run not finished after %0d cycles, errors: %0d", cycles, errors);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	// scoreboard, outputs are registered so the falling edge sees them settled
	always @(negedge clk) begin
		if (reset && load_retire.valid) begin
			if (exp_retire.size() == 0) begin
				$display("unexpected load retire for tag %h", load_retire.rob_tag);
				errors++;
			end else begin
				want_retire = exp_retire.pop_front();
				if (load_retire.rob_tag != want_retire.rob_tag) begin
					$display("[ERROR] load_retire.rob_tag: got %h, expected %h",
						load_retire.rob_tag, want_retire.rob_tag);
					errors++;
				end
				if (load_retire.order_fail != want_retire.order_fail) begin
					$display("[ERROR] load_retire.order_fail: got %h, expected %h",
						load_retire.order_fail, want_retire.order_fail);
					errors++;
				end
			end
		end
		if (reset && store_fire.valid) begin
			if (exp_fire.size() == 0) begin
				$display("unexpected store fire from index %h", store_fire.stq_index);
				errors++;
			end else begin
				want_fire = exp_fire.pop_front();
				if (store_fire.stq_index != want_fire.stq_index) begin
					$display("[ERROR] store_fire.stq_index: got %h, expected %h",
						store_fire.stq_index, want_fire.stq_index);
					errors++;
				end
				if (store_fire.address != want_fire.address) begin
					$display("[ERROR] store_fire.address: got %h, expected %h",
						store_fire.address, want_fire.address);
					errors++;
				end
				if (store_fire.data != want_fire.data) begin
					$display("[ERROR] store_fire.data: got %h, expected %h",
						store_fire.data, want_fire.data);
					errors++;
				end
			end
		end
	end

	function automatic tag_t fresh_tag();
		tag_t t;
		t = next_tag;
		next_tag = next_tag + 1'b1;
		return t;
	endfunction

	task automatic clear_inputs();
		ld_alloc = '0;
		st_alloc = '0;
		agu = '0;
		load_executed = '0;
		load_succeeded = '0;
		rob_commit = '0;
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, expected);
			errors++;
		end
	endtask

	// every driver starts 1 ns after a rising edge and ends there too
	task automatic send_event(input int bus, input tag_t tag);
		tag_event_t ev;
		ev.valid = 1'b1;
		ev.rob_tag = tag;
		case (bus)
			BUS_LD_ALLOC: ld_alloc = ev;
			BUS_ST_ALLOC: st_alloc = ev;
			BUS_EXECUTED: load_executed = ev;
			BUS_SUCCEEDED: load_succeeded = ev;
			default: rob_commit = ev;
		endcase
		@(posedge clk);
		#1;
		clear_inputs();
	endtask

	task automatic send_agu(input tag_t tag, input word_t address, input word_t data);
		agu.valid = 1'b1;
		agu.rob_tag = tag;
		agu.address = address;
		agu.data = data;
		@(posedge clk);
		#1;
		clear_inputs();
	endtask

	task automatic expect_retire(input tag_t tag, input logic order_fail);
		exp_retire.push_back({1'b1, tag, order_fail});
	endtask

	task automatic expect_fire(input stq_idx_t idx, input word_t address, input word_t data);
		exp_fire.push_back({1'b1, idx, address, data});
	endtask

	// only for stores that the queue accepts
	task automatic alloc_store(input tag_t tag, output stq_idx_t idx);
		idx = store_index;
		store_index = store_index + 1'b1;
		send_event(BUS_ST_ALLOC, tag);
	endtask

	task automatic run_store(input tag_t tag, input word_t address, input word_t data);
		stq_idx_t idx;
		alloc_store(tag, idx);
		send_agu(tag, address, data);
		expect_fire(idx, address, data);
		send_event(BUS_COMMIT, tag);
	endtask

	task automatic wait_drained();
		while (exp_retire.size() != 0 || exp_fire.size() != 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	// commit sampled at edge N, head freed at N+1, report visible after it
	task automatic commit_at_head(input tag_t tag);
		expect_retire(tag, 1'b0);
		rob_commit.valid = 1'b1;
		rob_commit.rob_tag = tag;
		@(posedge clk);
		#1;
		clear_inputs();
		check_flag("load_retire.valid", load_retire.valid, 1'b0);
		@(posedge clk);
		@(negedge clk);
		check_flag("load_retire.valid", load_retire.valid, 1'b1);
		@(posedge clk);
		#1;
	endtask

	task automatic test_fill_and_full();
		tag_t tags [`LDQ_SIZE];
		tag_t extra;
		for (int i = 0; i < `LDQ_SIZE; i++) begin
			check_flag("ldq_full", ldq_full, 1'b0);
			tags[i] = fresh_tag();
			send_event(BUS_LD_ALLOC, tags[i]);
		end
		check_flag("ldq_full", ldq_full, 1'b1);
		// ninth load is dropped
		extra = fresh_tag();
		send_event(BUS_LD_ALLOC, extra);
		check_flag("ldq_full", ldq_full, 1'b1);
		// out of order commits wait behind the head
		send_event(BUS_COMMIT, tags[3]);
		send_event(BUS_COMMIT, tags[1]);
		send_event(BUS_COMMIT, tags[2]);
		for (int i = 0; i < 4; i++) begin
			expect_retire(tags[i], 1'b0);
		end
		send_event(BUS_COMMIT, tags[0]);
		wait_drained();
		for (int i = 4; i < `LDQ_SIZE; i++) begin
			commit_at_head(tags[i]);
		end
		// a dropped load has no entry, so its commit must not retire anything
		send_event(BUS_COMMIT, extra);
		wait_drained();
		check_flag("ldq_full", ldq_full, 1'b0);
	endtask

	task automatic test_store_path();
		tag_t tags [`STQ_SIZE];
		stq_idx_t idx [`STQ_SIZE];
		tag_t extra;
		word_t data;
		check_flag("stq_full", stq_full, 1'b0);
		for (int i = 0; i < `STQ_SIZE; i++) begin
			tags[i] = fresh_tag();
			alloc_store(tags[i], idx[i]);
		end
		check_flag("stq_full", stq_full, 1'b1);
		extra = fresh_tag();
		send_event(BUS_ST_ALLOC, extra);
		check_flag("stq_full", stq_full, 1'b1);
		for (int i = 0; i < `STQ_SIZE; i++) begin
			data = $random(seed);
			send_agu(tags[i], 32'h2000 + i * 4, data);
			expect_fire(idx[i], 32'h2000 + i * 4, data);
			send_event(BUS_COMMIT, tags[i]);
		end
		send_agu(extra, 32'h2100, 32'hdead_beef);
		send_event(BUS_COMMIT, extra);
		wait_drained();
		check_flag("stq_full", stq_full, 1'b0);
	endtask

	// one store and one load, the store always commits first
	task automatic order_case(input logic load_first, input logic exec,
			input word_t load_addr, input word_t store_addr);
		tag_t st_tag;
		tag_t ld_tag;
		stq_idx_t st_idx;
		word_t data;
		logic fail;
		st_tag = fresh_tag();
		ld_tag = fresh_tag();
		data = $random(seed);
		if (load_first) begin
			send_event(BUS_LD_ALLOC, ld_tag);
			alloc_store(st_tag, st_idx);
		end else begin
			alloc_store(st_tag, st_idx);
			send_event(BUS_LD_ALLOC, ld_tag);
		end
		send_agu(ld_tag, load_addr, 32'h0);
		send_agu(st_tag, store_addr, data);
		if (exec) begin
			send_event(BUS_EXECUTED, ld_tag);
			send_event(BUS_SUCCEEDED, ld_tag);
		end
		// younger load that already ran on the same word
		fail = !load_first && exec && (load_addr == store_addr);
		expect_fire(st_idx, store_addr, data);
		expect_retire(ld_tag, fail);
		send_event(BUS_COMMIT, st_tag);
		send_event(BUS_COMMIT, ld_tag);
		wait_drained();
	endtask

	task automatic test_mask_clearing();
		tag_t s_tag;
		tag_t l_tag;
		tag_t f_tag;
		tag_t s2_tag;
		stq_idx_t s_idx;
		stq_idx_t s2_idx;
		s_tag = fresh_tag();
		l_tag = fresh_tag();
		alloc_store(s_tag, s_idx);
		send_event(BUS_LD_ALLOC, l_tag);
		send_agu(l_tag, 32'h3000, 32'h0);
		send_event(BUS_EXECUTED, l_tag);
		// S writes another word and leaves, its mask bit in L clears
		send_agu(s_tag, 32'h3100, 32'h1111_0000);
		expect_fire(s_idx, 32'h3100, 32'h1111_0000);
		send_event(BUS_COMMIT, s_tag);
		wait_drained();
		// seven more stores bring the tail back around to the index of S
		for (int i = 1; i < `STQ_SIZE; i++) begin
			f_tag = fresh_tag();
			run_store(f_tag, 32'h3200, 32'h5000 + i);
		end
		wait_drained();
		s2_tag = fresh_tag();
		alloc_store(s2_tag, s2_idx);
		send_agu(s2_tag, 32'h3000, 32'h2222_0000);
		expect_fire(s2_idx, 32'h3000, 32'h2222_0000);
		send_event(BUS_COMMIT, s2_tag);
		expect_retire(l_tag, 1'b0);
		send_event(BUS_COMMIT, l_tag);
		wait_drained();
	endtask

	task automatic test_random_mix();
		word_t r;
		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			// two words only, so addresses match about half the time
			order_case(r[0], r[1], r[2] ? 32'h4004 : 32'h4000, r[3] ? 32'h4004 : 32'h4000);
		end
	endtask

	initial begin
		seed = 32'h87ad58df;
		reset = 1'b0;
		clear_inputs();
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b1;

		test_fill_and_full();
		test_store_path();
		// match, other word, not executed, load older than the store
		order_case(1'b0, 1'b1, 32'h1000, 32'h1000);
		order_case(1'b0, 1'b1, 32'h1000, 32'h1040);
		order_case(1'b0, 1'b0, 32'h1000, 32'h1000);
		order_case(1'b1, 1'b1, 32'h1000, 32'h1000);
		test_mask_clearing();
		test_random_mix();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: sim.f
+incdir+rtl
rtl/lsu_pkg.sv
rtl/load_queue.sv
rtl/store_queue.sv
rtl/order_fail_checker.sv
rtl/lsu_top.sv
test/lsu_assert.sv
test/lsu_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = lsu_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides the result, a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
